// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	localparam int word_w     = 32;
	localparam int pc_w       = 10;
	localparam int dm_addr_w  = 12;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [pc_w-1:0]       pc_t;
	typedef logic [dm_addr_w-1:0]  dm_addr_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl
	} alu_op_t;

	typedef enum logic {
		src2_rb,
		src2_imm
	} src2_sel_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_load,
		wb_link
	} wb_sel_t;

	typedef enum logic [1:0] {
		pc_seq,
		pc_branch,
		pc_jump
	} pc_sel_t;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_memaccess,
		ph_writeback
	} phase_t;

	// major opcodes
	localparam logic [5:0] op_alu  = 6'b100000;
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori  = 6'b101100;
	localparam logic [5:0] op_xori = 6'b101011;
	localparam logic [5:0] op_movi = 6'b100010;
	localparam logic [5:0] op_lwi  = 6'b000010;
	localparam logic [5:0] op_swi  = 6'b001010;
	localparam logic [5:0] op_beq  = 6'b100110;
	localparam logic [5:0] op_j    = 6'b100100;
	localparam logic [5:0] op_jal  = 6'b100101;

	// sub-ops of op_alu
	localparam logic [4:0] sub_add  = 5'b00000;
	localparam logic [4:0] sub_sub  = 5'b00001;
	localparam logic [4:0] sub_and  = 5'b00010;
	localparam logic [4:0] sub_or   = 5'b00100;
	localparam logic [4:0] sub_xor  = 5'b00011;
	localparam logic [4:0] sub_slli = 5'b01000;
	localparam logic [4:0] sub_srli = 5'b01001;

	localparam reg_addr_t link_reg = 5'd31;

	// one instruction word, register form and immediate form
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			reg_addr_t  rt;
			reg_addr_t  ra;
			reg_addr_t  rb;
			logic [4:0] sa;
			logic [4:0] sub_op;
			logic       spare;
		} r;
		struct packed {
			logic [5:0]  opcode;
			reg_addr_t   rt;
			reg_addr_t   ra;
			logic [15:0] imm;
		} i;
	} instr_u;

endpackage

// ==== source/cpu_ctrl_if.sv ====
interface cpu_ctrl_if;
	import cpu_pkg::*;

	// decode
	logic      rd_en;
	reg_addr_t rt;
	reg_addr_t ra;
	reg_addr_t rb;
	word_t     imm_ext;

	// execute
	src2_sel_t src2_sel;
	alu_op_t   alu_op;
	logic      pc_en;
	pc_sel_t   pc_sel;

	// memaccess and writeback
	logic      ld_en;
	logic      wb_en;
	logic      reg_write;
	wb_sel_t   wb_sel;

	modport ctrl (
		output rd_en, rt, ra, rb, imm_ext,
		output src2_sel, alu_op, pc_en, pc_sel,
		output ld_en, wb_en, reg_write, wb_sel
	);

	modport exe (input src2_sel, alu_op, imm_ext, pc_en, reg_write, wb_sel);

	modport pcu (input pc_en, pc_sel, imm_ext);

	modport rf (input rd_en, rt, ra, rb, wb_en, reg_write);

	modport wb (input ld_en, wb_sel);

endinterface

// ==== source/cpu_controller.sv ====
module cpu_controller (
	input  logic           enable_memaccess,
	input  logic           rst,
	input  cpu_pkg::word_t instruction,
	input  logic           alu_zero,
	output logic           im_read,
	output logic           dm_read,
	output logic           dm_write,
	cpu_ctrl_if.ctrl       ctrl
);
	import cpu_pkg::*;

	phase_t phase;
	phase_t phase_next;
	instr_u instr;
	word_t  imm_sext;
	word_t  imm_zext;

	always_comb begin
		case (phase)
			ph_fetch:     phase_next = ph_decode;
			ph_decode:    phase_next = ph_execute;
			ph_execute:   phase_next = ph_memaccess;
			ph_memaccess: phase_next = ph_writeback;
			default:      phase_next = ph_fetch;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			phase <= ph_fetch;
			instr <= '0;
		end else begin
			phase <= phase_next;
			if (phase == ph_fetch)
				instr <= instruction;
		end
	end

	// one pulse per phase
	assign im_read    = (phase == ph_fetch);
	assign ctrl.rd_en = (phase == ph_decode);
	assign ctrl.pc_en = (phase == ph_execute);
	assign ctrl.ld_en = (phase == ph_memaccess);
	assign ctrl.wb_en = (phase == ph_writeback);

	assign dm_read  = (phase == ph_memaccess) && (instr.i.opcode == op_lwi);
	assign dm_write = (phase == ph_memaccess) && (instr.i.opcode == op_swi);

	assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign imm_zext = {16'b0, instr.i.imm};

	always_comb begin
		ctrl.rt        = instr.i.rt;
		ctrl.ra        = instr.i.ra;
		ctrl.rb        = instr.r.rb;
		ctrl.imm_ext   = imm_sext;
		ctrl.src2_sel  = src2_imm;
		ctrl.alu_op    = alu_add;
		ctrl.pc_sel    = pc_seq;
		ctrl.reg_write = 1'b0;
		ctrl.wb_sel    = wb_alu;
		case (instr.i.opcode)
			op_alu: begin
				ctrl.src2_sel  = src2_rb;
				ctrl.reg_write = 1'b1;
				case (instr.r.sub_op)
					sub_add: ctrl.alu_op = alu_add;
					sub_sub: ctrl.alu_op = alu_sub;
					sub_and: ctrl.alu_op = alu_and;
					sub_or:  ctrl.alu_op = alu_or;
					sub_xor: ctrl.alu_op = alu_xor;
					sub_slli: begin
						ctrl.alu_op   = alu_sll;
						ctrl.src2_sel = src2_imm;
						ctrl.imm_ext  = {27'b0, instr.r.sa};
					end
					sub_srli: begin
						ctrl.alu_op   = alu_srl;
						ctrl.src2_sel = src2_imm;
						ctrl.imm_ext  = {27'b0, instr.r.sa};
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: ctrl.reg_write = 1'b1;
			op_ori: begin
				ctrl.imm_ext   = imm_zext;
				ctrl.alu_op    = alu_or;
				ctrl.reg_write = 1'b1;
			end
			op_xori: begin
				ctrl.imm_ext   = imm_zext;
				ctrl.alu_op    = alu_xor;
				ctrl.reg_write = 1'b1;
			end
			op_movi: begin
				// r0 plus immediate
				ctrl.ra        = '0;
				ctrl.reg_write = 1'b1;
			end
			op_lwi: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = wb_load;
			end
			op_swi: ctrl.reg_write = 1'b0;
			op_beq: begin
				// rt compared through the rb read port
				ctrl.rb       = instr.i.rt;
				ctrl.src2_sel = src2_rb;
				ctrl.alu_op   = alu_sub;
				ctrl.pc_sel   = alu_zero ? pc_branch : pc_seq;
			end
			op_j: ctrl.pc_sel = pc_jump;
			op_jal: begin
				ctrl.pc_sel    = pc_jump;
				ctrl.rt        = link_reg;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = wb_link;
			end
			default: ctrl.reg_write = 1'b0;
		endcase
	end

endmodule

// ==== source/register_file.sv ====
module register_file (
	input  logic           enable_memaccess,
	input  logic           rst,
	cpu_ctrl_if.rf         ctrl,
	input  cpu_pkg::word_t wr_data,
	output cpu_pkg::word_t ra_data,
	output cpu_pkg::word_t rb_data,
	output cpu_pkg::word_t rt_data
);
	import cpu_pkg::*;

	word_t regs [num_regs];

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			for (int n = 0; n < num_regs; n++)
				regs[n] <= '0;
		end else if (ctrl.wb_en && ctrl.reg_write && (ctrl.rt != '0)) begin
			regs[ctrl.rt] <= wr_data;
		end
	end

	// operands held from decode until writeback
	always_ff @(posedge enable_memaccess) begin
		if (ctrl.rd_en) begin
			ra_data <= regs[ctrl.ra];
			rb_data <= regs[ctrl.rb];
			rt_data <= regs[ctrl.rt];
		end
	end

endmodule

// ==== source/alu.sv ====
module alu (
	input  logic           enable_memaccess,
	input  logic           rst,
	cpu_ctrl_if.exe        ctrl,
	input  cpu_pkg::word_t ra_data,
	input  cpu_pkg::word_t rb_data,
	output cpu_pkg::word_t alu_result,
	output logic           alu_zero,
	output logic           alu_overflow
);
	import cpu_pkg::*;

	word_t src2;
	word_t result_next;
	logic  ovf_next;
	logic  arith_op;

	assign src2 = (ctrl.src2_sel == src2_rb) ? rb_data : ctrl.imm_ext;

	always_comb begin
		ovf_next = 1'b0;
		case (ctrl.alu_op)
			alu_add: begin
				result_next = ra_data + src2;
				ovf_next = (ra_data[31] == src2[31]) && (result_next[31] != ra_data[31]);
			end
			alu_sub: begin
				result_next = ra_data - src2;
				ovf_next = (ra_data[31] != src2[31]) && (result_next[31] != ra_data[31]);
			end
			alu_and: result_next = ra_data & src2;
			alu_or:  result_next = ra_data | src2;
			alu_xor: result_next = ra_data ^ src2;
			alu_sll: result_next = ra_data << src2[4:0];
			alu_srl: result_next = ra_data >> src2[4:0];
			default: result_next = '0;
		endcase
	end

	// operands are stable through execute, so beq resolves in the same cycle
	assign alu_zero = (result_next == '0);

	// address and compare uses leave the flag alone
	assign arith_op = ctrl.reg_write && (ctrl.wb_sel == wb_alu);

	always_ff @(posedge enable_memaccess) begin
		if (ctrl.pc_en)
			alu_result <= result_next;
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst)
			alu_overflow <= 1'b0;
		else if (ctrl.pc_en && arith_op)
			alu_overflow <= ovf_next;
	end

endmodule

// ==== source/pc_unit.sv ====
module pc_unit (
	input  logic           enable_memaccess,
	input  logic           rst,
	cpu_ctrl_if.pcu        ctrl,
	output cpu_pkg::pc_t   pc,
	output cpu_pkg::word_t link_addr
);
	import cpu_pkg::*;

	pc_t pc_plus4;
	pc_t branch_target;
	pc_t jump_target;
	pc_t next_pc;

	assign pc_plus4 = pc + pc_t'(4);

	// word offset, scaled to bytes
	assign branch_target = pc_plus4 + {ctrl.imm_ext[pc_w-3:0], 2'b00};

	// absolute word index
	assign jump_target = {ctrl.imm_ext[pc_w-3:0], 2'b00};

	always_comb begin
		case (ctrl.pc_sel)
			pc_branch: next_pc = branch_target;
			pc_jump:   next_pc = jump_target;
			default:   next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			pc        <= '0;
			link_addr <= '0;
		end else if (ctrl.pc_en) begin
			pc        <= next_pc;
			link_addr <= word_t'(pc_plus4);
		end
	end

endmodule

// ==== source/writeback_select.sv ====
module writeback_select (
	input  logic           enable_memaccess,
	input  logic           rst,
	cpu_ctrl_if.wb         ctrl,
	input  cpu_pkg::word_t alu_result,
	input  cpu_pkg::word_t dm_out,
	input  cpu_pkg::word_t link_addr,
	output cpu_pkg::word_t wr_data
);
	import cpu_pkg::*;

	word_t load_data;

	always_ff @(posedge enable_memaccess) begin
		if (rst)
			load_data <= '0;
		else if (ctrl.ld_en)
			load_data <= dm_out;
	end

	always_comb begin
		case (ctrl.wb_sel)
			wb_load: wr_data = load_data;
			wb_link: wr_data = link_addr;
			default: wr_data = alu_result;
		endcase
	end

endmodule

// ==== source/cpu_top.sv ====
module cpu_top (
	input  logic              enable_memaccess,
	input  logic              rst,
	input  cpu_pkg::word_t    instruction,
	output logic              im_read,
	output cpu_pkg::pc_t      im_address,
	output logic              dm_read,
	output logic              dm_write,
	output cpu_pkg::dm_addr_t dm_address,
	output cpu_pkg::word_t    dm_in,
	input  cpu_pkg::word_t    dm_out,
	output logic              alu_overflow
);
	import cpu_pkg::*;

	word_t alu_result;
	logic  alu_zero;
	word_t ra_data;
	word_t rb_data;
	word_t link_addr;
	word_t wr_data;

	cpu_ctrl_if i_ctrl_if ();

	cpu_controller i_controller (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.instruction      (instruction),
		.alu_zero         (alu_zero),
		.im_read          (im_read),
		.dm_read          (dm_read),
		.dm_write         (dm_write),
		.ctrl             (i_ctrl_if.ctrl)
	);

	register_file i_register_file (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.ctrl             (i_ctrl_if.rf),
		.wr_data          (wr_data),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.rt_data          (dm_in)
	);

	alu i_alu (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.ctrl             (i_ctrl_if.exe),
		.ra_data          (ra_data),
		.rb_data          (rb_data),
		.alu_result       (alu_result),
		.alu_zero         (alu_zero),
		.alu_overflow     (alu_overflow)
	);

	pc_unit i_pc_unit (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.ctrl             (i_ctrl_if.pcu),
		.pc               (im_address),
		.link_addr        (link_addr)
	);

	writeback_select i_writeback_select (
		.enable_memaccess (enable_memaccess),
		.rst              (rst),
		.ctrl             (i_ctrl_if.wb),
		.alu_result       (alu_result),
		.dm_out           (dm_out),
		.link_addr        (link_addr),
		.wr_data          (wr_data)
	);

	assign dm_address = alu_result[dm_addr_w-1:0];

endmodule

// ==== bench/clock_gen.sv ====
module clock_gen (
	output logic clk,
	output logic rst
);

	// period 8
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// three rising edges in reset
	initial begin
		rst = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== bench/cpu_tb.sv ====
module cpu_tb;
	import cpu_pkg::*;

	logic     clk;
	logic     por;
	logic     test_rst = 1'b1;
	logic     rst;
	word_t    instruction;
	logic     im_read;
	pc_t      im_address;
	logic     dm_read;
	logic     dm_write;
	dm_addr_t dm_address;
	word_t    dm_in;
	word_t    dm_out;
	logic     alu_overflow;

	word_t    imem [256];
	word_t    dmem [1024];
	word_t    prog [$];
	pc_t      fetch_pc [$];
	int       fetch_cyc [$];
	dm_addr_t st_addr [$];
	word_t    st_data [$];
	int       cyc;
	int       mem_strobes;
	int       reads;
	int       errors = 0;
	int       cycles = 0;
	int       seed = 32'hfda3f1c8;
	// 48 instructions over all tests
	int       timeout_cycles = 48 * 5 + 50;

	assign rst = por | test_rst;
	assign instruction = imem[im_address[9:2]];
	assign dm_out = dmem[dm_address[11:2]];

	clock_gen i_clock_gen (
		.clk (clk),
		.rst (por)
	);

	cpu_top i_cpu_top (
		.enable_memaccess (clk),
		.rst              (rst),
		.instruction      (instruction),
		.im_read          (im_read),
		.im_address       (im_address),
		.dm_read          (dm_read),
		.dm_write         (dm_write),
		.dm_address       (dm_address),
		.dm_in            (dm_in),
		.dm_out           (dm_out),
		.alu_overflow     (alu_overflow)
	);

	function automatic word_t enc_r(input logic [4:0] sub, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb, input logic [4:0] sa);
		return {op_alu, rt, ra, rb, sa, sub, 1'b0};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t ra, input logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic word_t sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// initial data memory content that differs for every word address
	function automatic word_t fill_word(input int idx);
		return (word_t'(idx) * 32'h0100_0193) ^ 32'h5ac3_0000;
	endfunction

	function automatic word_t next_random();
		return $random(seed);
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail at time %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_daddr(input string name, input dm_addr_t exp, input dm_addr_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail at time %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_pc(input string name, input pc_t exp, input pc_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail at time %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input bit act);
		if (act != exp) begin
			errors++;
			$display("Fail at time %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_store(input int n, input dm_addr_t addr, input word_t data);
		if (n >= st_addr.size()) begin
			errors++;
			$display("store number %0d never reached data memory", n);
		end else begin
			check_daddr("dm_address", addr, st_addr[n]);
			check_word("dm_in", data, st_data[n]);
		end
	endtask

	task automatic check_store_count(input int n);
		if (st_addr.size() != n) begin
			errors++;
			$display("expected %0d stores to data memory but saw %0d", n, st_addr.size());
		end
	endtask

	task automatic check_fetch(input int n, input pc_t exp);
		if (n >= fetch_pc.size()) begin
			errors++;
			$display("fetch number %0d never happened", n);
		end else begin
			check_pc("im_address", exp, fetch_pc[n]);
		end
	endtask

	// load the program and hold reset for three cycles
	task automatic start_program();
		int k;
		@(negedge clk);
		test_rst = 1'b1;
		for (k = 0; k < 256; k++)
			imem[k] = (k < prog.size()) ? prog[k] : '0;
		for (k = 0; k < 1024; k++)
			dmem[k] = fill_word(k);
		fetch_pc.delete();
		fetch_cyc.delete();
		st_addr.delete();
		st_data.delete();
		cyc = 0;
		mem_strobes = 0;
		reads = 0;
		repeat (3) @(negedge clk);
		test_rst = 1'b0;
	endtask

	// outputs sampled mid cycle where stores also land in the model
	task automatic run_instrs(input int n);
		repeat (n * 5) begin
			if (im_read) begin
				fetch_pc.push_back(im_address);
				fetch_cyc.push_back(cyc);
			end
			if (dm_read)
				reads++;
			if (dm_read || dm_write)
				mem_strobes++;
			if (dm_write) begin
				st_addr.push_back(dm_address);
				st_data.push_back(dm_in);
				dmem[dm_address[11:2]] = dm_in;
			end
			cyc++;
			@(negedge clk);
		end
	endtask

	task automatic test_reset_fetch();
		int k;
		prog.delete();
		prog.push_back(enc_i(op_movi, 5'd1, 5'd0, 16'h0040));
		prog.push_back(enc_i(op_addi, 5'd2, 5'd1, 16'h0007));
		prog.push_back(enc_i(op_xori, 5'd3, 5'd2, 16'h0001));
		prog.push_back(enc_i(op_swi, 5'd2, 5'd1, 16'h0000));
		start_program();
		run_instrs(3);
		check_word("memory strobe cycles", 32'd0, word_t'(mem_strobes));
		run_instrs(1);
		for (k = 0; k < 4; k++)
			check_fetch(k, pc_t'(4 * k));
		if (fetch_cyc.size() > 0)
			check_word("first fetch cycle", 32'd0, word_t'(fetch_cyc[0]));
		for (k = 1; k < fetch_cyc.size(); k++)
			check_word("fetch spacing", 32'd5, word_t'(fetch_cyc[k] - fetch_cyc[k-1]));
		check_store_count(1);
		check_store(0, 12'h040, 32'h0000_0047);
	endtask

	task automatic test_register_ops();
		word_t       r;
		logic [15:0] ia;
		logic [15:0] ib;
		logic [4:0]  sa;
		word_t       a;
		word_t       b;
		word_t       exp [8];
		int          k;
		r = next_random();
		ia = r[15:0];
		// negative so the movi sign extension reaches every result
		ib = r[31:16] | 16'h8000;
		r = next_random();
		sa = r[4:0];
		a = sext16(ia);
		b = sext16(ib);
		exp[0] = a + b;
		exp[1] = a - b;
		exp[2] = a & b;
		exp[3] = a | b;
		exp[4] = a ^ b;
		exp[5] = a << sa;
		exp[6] = a >> sa;
		// r0 after a write
		exp[7] = '0;
		prog.delete();
		prog.push_back(enc_i(op_movi, 5'd1, 5'd0, ia));
		prog.push_back(enc_i(op_movi, 5'd2, 5'd0, ib));
		prog.push_back(enc_r(sub_add, 5'd3, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(sub_sub, 5'd4, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(sub_and, 5'd5, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(sub_or, 5'd6, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(sub_xor, 5'd7, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(sub_slli, 5'd8, 5'd1, 5'd0, sa));
		prog.push_back(enc_r(sub_srli, 5'd9, 5'd1, 5'd0, sa));
		prog.push_back(enc_r(sub_add, 5'd0, 5'd1, 5'd2, 5'd0));
		for (k = 0; k < 8; k++)
			prog.push_back(enc_i(op_swi, (k < 7) ? reg_addr_t'(k + 3) : 5'd0, 5'd0,
				16'(16'h0100 + 4 * k)));
		start_program();
		run_instrs(18);
		check_store_count(8);
		for (k = 0; k < 8; k++)
			check_store(k, dm_addr_t'(12'h100 + 4 * k), exp[k]);
	endtask

	task automatic test_immediate_ops();
		word_t       r;
		logic [15:0] ia;
		logic [15:0] i1;
		logic [15:0] i2;
		logic [15:0] i3;
		word_t       a;
		r = next_random();
		// positive base and negative immediates, so zero and sign extension differ
		ia = {1'b0, r[14:0]};
		i1 = r[31:16] | 16'h8000;
		r = next_random();
		i2 = r[15:0] | 16'h8000;
		i3 = r[31:16] | 16'h8000;
		a = sext16(ia);
		prog.delete();
		prog.push_back(enc_i(op_movi, 5'd1, 5'd0, ia));
		prog.push_back(enc_i(op_addi, 5'd2, 5'd1, i1));
		prog.push_back(enc_i(op_ori, 5'd3, 5'd1, i2));
		prog.push_back(enc_i(op_xori, 5'd4, 5'd1, i3));
		prog.push_back(enc_i(op_swi, 5'd2, 5'd0, 16'h0180));
		prog.push_back(enc_i(op_swi, 5'd3, 5'd0, 16'h0184));
		prog.push_back(enc_i(op_swi, 5'd4, 5'd0, 16'h0188));
		// 0x40000000 doubled
		prog.push_back(enc_i(op_movi, 5'd5, 5'd0, 16'h4000));
		prog.push_back(enc_r(sub_slli, 5'd5, 5'd5, 5'd0, 5'd16));
		prog.push_back(enc_r(sub_add, 5'd6, 5'd5, 5'd5, 5'd0));
		prog.push_back(enc_r(sub_add, 5'd7, 5'd1, 5'd1, 5'd0));
		prog.push_back(enc_i(op_swi, 5'd6, 5'd0, 16'h018c));
		start_program();
		run_instrs(10);
		check_flag("alu_overflow", 1'b1, alu_overflow);
		run_instrs(1);
		check_flag("alu_overflow", 1'b0, alu_overflow);
		run_instrs(1);
		check_store_count(4);
		check_store(0, 12'h180, a + sext16(i1));
		check_store(1, 12'h184, a | {16'h0000, i2});
		check_store(2, 12'h188, a ^ {16'h0000, i3});
		check_store(3, 12'h18c, 32'h8000_0000);
	endtask

	task automatic test_load_store();
		word_t       r;
		logic [15:0] base;
		logic [15:0] off;
		logic [15:0] val;
		r = next_random();
		base = 16'h0100 + {6'b0, r[9:2], 2'b00};
		off = {10'b0, r[15:12], 2'b00};
		val = r[31:16];
		prog.delete();
		prog.push_back(enc_i(op_movi, 5'd1, 5'd0, base));
		prog.push_back(enc_i(op_movi, 5'd2, 5'd0, val));
		prog.push_back(enc_i(op_swi, 5'd2, 5'd1, off));
		prog.push_back(enc_i(op_lwi, 5'd3, 5'd1, off));
		prog.push_back(enc_i(op_swi, 5'd3, 5'd0, 16'h0800));
		// negative offset into untouched memory
		prog.push_back(enc_i(op_lwi, 5'd4, 5'd1, 16'hfff8));
		prog.push_back(enc_i(op_swi, 5'd4, 5'd0, 16'h0804));
		start_program();
		run_instrs(7);
		check_store_count(3);
		check_store(0, dm_addr_t'(base + off), sext16(val));
		check_store(1, 12'h800, sext16(val));
		check_store(2, 12'h804, fill_word(int'((base - 16'd8) >> 2)));
		check_word("dm_read cycles", 32'd2, word_t'(reads));
	endtask

	task automatic test_control_flow();
		word_t       r;
		logic [15:0] v;
		word_t       trap;
		r = next_random();
		v = r[15:0] | 16'h0001;
		// skipped slots store to an address no test expects
		trap = enc_i(op_swi, 5'd0, 5'd0, 16'h03fc);
		prog.delete();
		prog.push_back(enc_i(op_movi, 5'd1, 5'd0, v));
		prog.push_back(enc_i(op_movi, 5'd2, 5'd0, v));
		prog.push_back(enc_i(op_beq, 5'd2, 5'd1, 16'd2));
		prog.push_back(trap);
		prog.push_back(trap);
		prog.push_back(enc_i(op_beq, 5'd0, 5'd1, 16'd1));
		prog.push_back(enc_i(op_j, 5'd0, 5'd0, 16'd9));
		prog.push_back(trap);
		prog.push_back(trap);
		prog.push_back(enc_i(op_jal, 5'd0, 5'd0, 16'd12));
		prog.push_back(trap);
		prog.push_back(trap);
		prog.push_back(enc_i(op_swi, link_reg, 5'd0, 16'h0100));
		start_program();
		run_instrs(7);
		check_fetch(0, 10'd0);
		check_fetch(1, 10'd4);
		check_fetch(2, 10'd8);
		check_fetch(3, 10'd20);
		check_fetch(4, 10'd24);
		check_fetch(5, 10'd36);
		check_fetch(6, 10'd48);
		check_store_count(1);
		check_store(0, 12'h100, 32'd40);
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int k;
		for (k = 0; k < 256; k++)
			imem[k] = '0;
		for (k = 0; k < 1024; k++)
			dmem[k] = fill_word(k);
		test_reset_fetch();
		test_register_ops();
		test_immediate_ops();
		test_load_store();
		test_control_flow();
		$display("%0d errors after %0d cycles", errors, cycles);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== cpu.f ====
source/cpu_pkg.sv
source/cpu_ctrl_if.sv
source/cpu_controller.sv
source/register_file.sv
source/alu.sv
source/pc_unit.sv
source/writeback_select.sv
source/cpu_top.sv
bench/clock_gen.sv
bench/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f cpu.f \
	--top-module cpu_tb \
	-o cpu_sim

./obj_dir/cpu_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "cpu testbench reported errors, see sim.log"
	exit 1
fi

echo "cpu testbench finished cleanly"
